// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tpl_dac
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIMFLAGS  = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
tpl_dac_pkg.sv
tpl_dac_regs_pkg.sv
tpl_dac_regmap.sv
tpl_dac_channel_source.sv
tpl_dac_framer.sv
tpl_dac_top.sv
tpl_dac_props.sv
tb_tpl_dac.sv

// File: tb_tpl_dac.sv
/*
 * Testbench for the DAC transport layer. Drives the Wishbone registers,
 * the user samples and link_ready, predicts link_data from the register
 * rules and compares it on every clock with immediate assertions.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_tpl_dac
  import tpl_dac_pkg::*;
  import tpl_dac_regs_pkg::*;
();

  localparam int          clk_period     = 100;
  localparam int          timeout_cycles = 600;
  localparam logic [31:0] seed           = 32'h68da;

  logic       link_clk;
  logic       reset;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  logic       link_ready;
  dac_data_t  dac_data;
  link_data_t link_data;

  // Registers as the DUT should hold them after each accepted write
  logic          exp_enable;
  logic          exp_offset_binary;
  source_mode_e  exp_mode0;
  source_mode_e  exp_mode1;
  sample_t       exp_pattern0;
  sample_t       exp_pattern1;
  sample_t       exp_ramp0;
  sample_t       exp_ramp1;
  logic          exp_ack;

  // Expected pipeline: source outputs, then the framed lanes
  channel_data_t exp_src0;
  channel_data_t exp_src1;
  link_data_t    exp_link;

  int unsigned   link_errors = 0;
  int unsigned   ack_errors = 0;
  int unsigned   read_errors = 0;
  int unsigned   cycles = 0;
  logic [31:0]   rng_state;

  tpl_dac_top dut_i (
    .link_clk   (link_clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .link_ready (link_ready),
    .link_data  (link_data),
    .dac_data   (dac_data)
  );

  // Bus and reset properties ride along inside the DUT
  bind tpl_dac_top tpl_dac_props props_i (
    .link_clk  (link_clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .link_data (link_data)
  );

  initial begin
    link_clk = 1'b0;
    forever #(clk_period / 2) link_clk = ~link_clk;
  end

  // ********************
  // Model helpers
  // ********************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One channel's beat as the source rules describe it
  function automatic channel_data_t expected_beat(input source_mode_e mode,
      input sample_t pattern, input sample_t ramp, input channel_data_t ext,
      input logic en, input logic ob);
    channel_data_t beat;
    sample_t       s;
    beat = '0;
    if (en && mode != mode_zero) begin
      for (int j = 0; j < samples_per_beat; j++) begin
        case (mode)
          mode_pattern: s = pattern;
          mode_ramp:    s = ramp + sample_t'(j);
          default:      s = ext[j*16 +: 16];
        endcase
        // Offset binary flips the sign bit
        if (ob) s[15] = ~s[15];
        beat[j*16 +: 16] = s;
      end
    end
    return beat;
  endfunction

  // Ramp base steps by a full beat only when enabled and the link is ready
  function automatic sample_t next_ramp(input source_mode_e mode, input sample_t ramp,
      input logic en, input logic ready);
    if (mode != mode_ramp) return '0;
    if (en && ready) return ramp + 16'd4;
    return ramp;
  endfunction

  // High byte to lane 2i, low byte to lane 2i+1, byte j for sample j
  function automatic link_data_t frame_lanes(input channel_data_t ch0,
      input channel_data_t ch1);
    link_data_t    lanes;
    channel_data_t beat;
    sample_t       s;
    lanes = '0;
    for (int i = 0; i < 2; i++) begin
      beat = (i == 0) ? ch0 : ch1;
      for (int j = 0; j < 4; j++) begin
        s = beat[j*16 +: 16];
        lanes[64*i + 8*j +: 8]      = s[15:8];
        lanes[64*i + 32 + 8*j +: 8] = s[7:0];
      end
    end
    return lanes;
  endfunction

  function automatic wb_data_t mode_word(input source_mode_e m0, input source_mode_e m1);
    wb_data_t w;
    w      = '0;
    w[1:0] = m0;
    w[3:2] = m1;
    return w;
  endfunction

  // ********************
  // Reference model
  // ********************

  // Reads only pre-edge values, so it lines up with the DUT registers
  always @(posedge link_clk) begin : reference_model
    logic accept;
    accept = wb_cyc && wb_stb && !exp_ack;
    if (reset) begin
      exp_enable        <= 1'b0;
      exp_offset_binary <= 1'b0;
      exp_mode0         <= mode_zero;
      exp_mode1         <= mode_zero;
      exp_pattern0      <= '0;
      exp_pattern1      <= '0;
      exp_ramp0         <= '0;
      exp_ramp1         <= '0;
      exp_ack           <= 1'b0;
      exp_src0          <= '0;
      exp_src1          <= '0;
      exp_link          <= '0;
    end else begin
      assert (link_data === exp_link) else begin
        link_errors++;
        $display("MISMATCH link_data expected %h actual %h", exp_link, link_data);
      end
      // Ack comes exactly one clock after the request
      assert (wb_ack === exp_ack) else begin
        ack_errors++;
        $display("MISMATCH wb_ack expected %h actual %h", exp_ack, wb_ack);
      end
      exp_src0  <= expected_beat(exp_mode0, exp_pattern0, exp_ramp0, dac_data[63:0],
                                 exp_enable, exp_offset_binary);
      exp_src1  <= expected_beat(exp_mode1, exp_pattern1, exp_ramp1, dac_data[127:64],
                                 exp_enable, exp_offset_binary);
      exp_ramp0 <= next_ramp(exp_mode0, exp_ramp0, exp_enable, link_ready);
      exp_ramp1 <= next_ramp(exp_mode1, exp_ramp1, exp_enable, link_ready);
      exp_link  <= frame_lanes(exp_src0, exp_src1);
      exp_ack   <= accept;
      // A write lands on the edge that accepts the request
      if (accept && wb_we) begin
        case (wb_adr)
          addr_control: begin
            exp_enable        <= wb_dat_w[0];
            exp_offset_binary <= wb_dat_w[1];
          end
          addr_mode: begin
            exp_mode0 <= source_mode_e'(wb_dat_w[1:0]);
            exp_mode1 <= source_mode_e'(wb_dat_w[3:2]);
          end
          addr_pattern0: exp_pattern0 <= wb_dat_w[15:0];
          addr_pattern1: exp_pattern1 <= wb_dat_w[15:0];
          default: ;
        endcase
      end
    end
  end

  // ********************
  // Bus and stimulus tasks
  // ********************

  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    @(posedge link_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= addr;
    wb_dat_w <= data;
    do @(posedge link_clk); while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
    @(posedge link_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= addr;
    do @(posedge link_clk); while (!wb_ack);
    data = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic expect_equal(input string name, input wb_data_t expected,
      input wb_data_t actual);
    assert (actual === expected) else begin
      read_errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic draw_word(output logic [31:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
  endtask

  task automatic draw_beat(output dac_data_t beat);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      draw_word(w);
      beat[32*k +: 32] = w;
    end
  endtask

  // Stops a run that never reaches its end
  always @(posedge link_clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ********************
  // Test sequence
  // ********************

  initial begin : stimulus
    wb_data_t    rd;
    dac_data_t   beat;
    logic [31:0] w;
    sample_t     pat0;
    sample_t     pat1;
    int          stall;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    link_ready = 1'b1;
    dac_data   = '0;
    rng_state  = seed;
    repeat (10) @(posedge link_clk);
    reset <= 1'b0;

    // Reset values and the version register
    wb_read(addr_version, rd);
    expect_equal("wb_dat_r version", version_value, rd);
    wb_read(addr_control, rd);
    expect_equal("wb_dat_r control", 32'h0, rd);

    // External samples in two's complement, a new beat every cycle
    wb_write(addr_mode, mode_word(mode_external, mode_external));
    wb_write(addr_control, 32'h1);
    repeat (50) begin
      @(posedge link_clk);
      draw_beat(beat);
      dac_data <= beat;
    end

    // Constant patterns in offset binary
    draw_word(w);
    pat0 = w[15:0];
    pat1 = w[31:16];
    wb_write(addr_pattern0, {16'h0, pat0});
    wb_write(addr_pattern1, {16'h0, pat1});
    wb_read(addr_pattern0, rd);
    expect_equal("wb_dat_r pattern0", {16'h0, pat0}, rd);
    wb_read(addr_pattern1, rd);
    expect_equal("wb_dat_r pattern1", {16'h0, pat1}, rd);
    wb_write(addr_control, 32'h3);
    wb_write(addr_mode, mode_word(mode_pattern, mode_pattern));
    repeat (6) @(posedge link_clk);
    expect_equal("link_data lane0", {4{pat0[15:8] ^ 8'h80}}, link_data[31:0]);
    expect_equal("link_data lane3", {4{pat1[7:0]}}, link_data[127:96]);

    // Ramp with a random stall on link_ready
    wb_write(addr_control, 32'h1);
    wb_write(addr_mode, mode_word(mode_ramp, mode_ramp));
    repeat (20) @(posedge link_clk);
    draw_word(w);
    stall = 6 + int'(w % 10);
    link_ready <= 1'b0;
    repeat (stall) @(posedge link_clk);
    link_ready <= 1'b1;
    repeat (20) @(posedge link_clk);

    // Channel 0 muted while channel 1 keeps ramping, then all disabled
    wb_write(addr_mode, mode_word(mode_pattern, mode_ramp));
    repeat (8) @(posedge link_clk);
    wb_write(addr_mode, mode_word(mode_zero, mode_ramp));
    repeat (8) @(posedge link_clk);
    wb_write(addr_control, 32'h0);
    repeat (8) @(posedge link_clk);

    // Unknown address acks, reads zero and leaves the map alone
    wb_write(6'h20, 32'hFFFF_FFFF);
    wb_read(6'h20, rd);
    expect_equal("wb_dat_r unknown", 32'h0, rd);
    wb_read(addr_control, rd);
    expect_equal("wb_dat_r control", {30'h0, exp_offset_binary, exp_enable}, rd);
    wb_read(addr_mode, rd);
    expect_equal("wb_dat_r mode", mode_word(exp_mode0, exp_mode1), rd);
    wb_read(addr_pattern0, rd);
    expect_equal("wb_dat_r pattern0", {16'h0, exp_pattern0}, rd);
    wb_read(addr_pattern1, rd);
    expect_equal("wb_dat_r pattern1", {16'h0, exp_pattern1}, rd);
    wb_read(addr_version, rd);
    expect_equal("wb_dat_r version", version_value, rd);
    repeat (4) @(posedge link_clk);

    $display("Errors: link_data %0d, wb_ack %0d, register reads %0d, properties %0d",
             link_errors, ack_errors, read_errors, dut_i.props_i.fail_count);
    if (link_errors == 0 && ack_errors == 0 && read_errors == 0 &&
        dut_i.props_i.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tpl_dac_channel_source.sv
/*
 * Sample generator for one converter channel. Selects zero, a constant
 * pattern, a ramp or the user samples and applies the data format.
 */

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_channel_source
  import tpl_dac_pkg::*;
  import tpl_dac_regs_pkg::*;
(
  input  logic          link_clk,
  input  logic          reset,
  input  logic          enable,
  input  logic          offset_binary,
  input  logic          link_ready,
  input  source_mode_e  mode,
  input  sample_t       pattern,
  input  channel_data_t external,
  output channel_data_t samples
);

  sample_t       ramp_count;
  channel_data_t raw_samples;
  channel_data_t msb_mask;
  channel_data_t next_samples;

  // ********************
  // Ramp counter
  // ********************

  // The counter holds the first sample of the current beat.
  // It restarts from zero whenever the channel is not in ramp mode,
  // and holds while the link layer is not taking data
  always_ff @(posedge link_clk) begin
    if (reset) begin
      ramp_count <= '0;
    end else if (mode != mode_ramp) begin
      ramp_count <= '0;
    end else if (enable && link_ready) begin
      ramp_count <= ramp_count + sample_t'(samples_per_beat);
    end
  end

  // ********************
  // Source selection
  // ********************

  always_comb begin
    raw_samples = '0;
    msb_mask    = '0;

    // Sign bit of every sample in the beat
    for (int j = 0; j < samples_per_beat; j++) begin
      msb_mask[j*sample_width + sample_width - 1] = 1'b1;
    end

    case (mode)
      mode_pattern: begin
        for (int j = 0; j < samples_per_beat; j++) begin
          raw_samples[j*sample_width +: sample_width] = pattern;
        end
      end
      mode_ramp: begin
        // Samples within the beat rise by one from the counter base
        for (int j = 0; j < samples_per_beat; j++) begin
          raw_samples[j*sample_width +: sample_width] = ramp_count + sample_t'(j);
        end
      end
      mode_external: raw_samples = external;
      default:       raw_samples = '0;
    endcase
  end

  // Offset binary is two's complement with the MSB flipped.
  // A disabled channel or zero mode stays at all zeros in both formats
  always_comb begin
    if (!enable || mode == mode_zero) begin
      next_samples = '0;
    end else if (offset_binary) begin
      next_samples = raw_samples ^ msb_mask;
    end else begin
      next_samples = raw_samples;
    end
  end

  // Output register, one cycle from the control inputs
  always_ff @(posedge link_clk) begin
    if (reset) begin
      samples <= '0;
    end else begin
      samples <= next_samples;
    end
  end

endmodule

`default_nettype wire

// File: tpl_dac_framer.sv
/*
 * Maps the two channels' samples onto the four link lanes and registers
 * the result. Each channel owns a lane pair: high bytes, then low bytes.
 */

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_framer
  import tpl_dac_pkg::*;
(
  input  logic          link_clk,
  input  logic          reset,
  input  channel_data_t ch0_samples,
  input  channel_data_t ch1_samples,
  output link_data_t    link_data
);

  dac_data_t  ch_data;
  link_data_t link_next;

  // Channel i at bits 64i upward, the same layout as the user input
  assign ch_data = {ch1_samples, ch0_samples};

  // ********************
  // Octet mapping
  // ********************

  // High density case, one sample per octet pair.
  // Sample j of channel i puts its high byte in byte j of lane 2i
  // and its low byte in byte j of lane 2i+1
  always_comb begin
    int hi_lane;
    int sample_lsb;

    link_next = '0;
    for (int i = 0; i < num_channels; i++) begin
      hi_lane = i * lanes_per_channel;
      for (int j = 0; j < samples_per_beat; j++) begin
        sample_lsb = i * channel_width + j * sample_width;
        link_next[hi_lane*lane_width + j*octet_width +: octet_width] =
          ch_data[sample_lsb + octet_width +: octet_width];
        link_next[(hi_lane+1)*lane_width + j*octet_width +: octet_width] =
          ch_data[sample_lsb +: octet_width];
      end
    end
  end

  // The link sees zeros until the first beat after reset
  always_ff @(posedge link_clk) begin
    if (reset) begin
      link_data <= '0;
    end else begin
      link_data <= link_next;
    end
  end

endmodule

`default_nettype wire

// File: tpl_dac_pkg.sv
/*
 * Link geometry and sample types for the JESD204 DAC transport layer.
 * Imported by the datapath modules and the top level.
 */

`default_nettype none

package tpl_dac_pkg;

  // ********************
  // Link geometry
  // ********************

  // Four 32-bit lanes carry two converter channels
  localparam int num_lanes        = 4;
  localparam int num_channels     = 2;
  localparam int samples_per_beat = 4;

  // Widths of the basic units on the link
  localparam int octet_width       = 8;
  localparam int sample_width      = 16;
  localparam int lane_width        = 32;
  localparam int lanes_per_channel = num_lanes / num_channels;
  localparam int channel_width     = samples_per_beat * sample_width;

  // ********************
  // Sample types
  // ********************

  typedef logic [sample_width-1:0] sample_t;

  // One channel's beat, sample j at bits 16j upward
  typedef logic [channel_width-1:0] channel_data_t;

  // All lanes, lane n at bits 32n upward
  typedef logic [num_lanes*lane_width-1:0] link_data_t;

  // User samples, channel i at bits 64i upward
  typedef logic [num_channels*channel_width-1:0] dac_data_t;

endpackage

`default_nettype wire

// File: tpl_dac_props.sv
/*
 * Concurrent properties of the transport layer top level, bound into
 * tpl_dac_top: single-cycle Wishbone acks and clean outputs after reset.
 */

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_props
  import tpl_dac_pkg::*;
(
  input logic       link_clk,
  input logic       reset,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_ack,
  input link_data_t link_data
);

  // One counter per property, summed for the closing line
  int unsigned double_ack_fails = 0;
  int unsigned orphan_ack_fails = 0;
  int unsigned reset_fails      = 0;
  int unsigned fail_count;

  assign fail_count = double_ack_fails + orphan_ack_fails + reset_fails;

  // ********************
  // Wishbone handshake
  // ********************

  // Ack is a single pulse per request
  no_double_ack: assert property (@(posedge link_clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else begin
      double_ack_fails++;
      $error("wb_ack stayed high for two consecutive cycles");
    end

  // Ack answers a request seen on the previous edge
  ack_after_request: assert property (@(posedge link_clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
      orphan_ack_fails++;
      $error("wb_ack rose without a request in the previous cycle");
    end

  // First cycle out of reset sees no ack and an idle link
  clean_after_reset: assert property (@(posedge link_clk)
    ($past(reset) && !reset) |-> (!wb_ack && link_data == '0))
    else begin
      reset_fails++;
      $error("wb_ack or link_data not zero in the cycle after reset");
    end

endmodule

`default_nettype wire

// File: tpl_dac_regmap.sv
/*
 * Wishbone classic slave with the transport layer control registers.
 * Each request is acked one clock later and writes land on that edge.
 */

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_regmap
  import tpl_dac_pkg::*;
  import tpl_dac_regs_pkg::*;
(
  input  logic         link_clk,
  input  logic         reset,

  // Wishbone classic slave
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  wb_addr_t     wb_adr,
  input  wb_data_t     wb_dat_w,
  output wb_data_t     wb_dat_r,
  output logic         wb_ack,

  // Controls shared by both channels
  output logic         enable,
  output logic         offset_binary,

  // Per-channel source selection
  output source_mode_e mode0,
  output source_mode_e mode1,
  output sample_t      pattern0,
  output sample_t      pattern1
);

  logic     request;
  logic     access;
  wb_data_t read_data;

  // A request is live while both cyc and stb are high
  assign request = wb_cyc && wb_stb;

  // The cycle that carries ack never starts a second access, so the
  // master sees one ack per request even if it is slow to drop stb
  assign access = request && !wb_ack;

  // ********************
  // Bus handshake
  // ********************

  always_ff @(posedge link_clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  // ********************
  // Control registers
  // ********************

  // Writes take effect on the same edge that raises ack
  always_ff @(posedge link_clk) begin
    if (reset) begin
      enable        <= 1'b0;
      offset_binary <= 1'b0;
      mode0         <= mode_zero;
      mode1         <= mode_zero;
      pattern0      <= '0;
      pattern1      <= '0;
    end else if (access && wb_we) begin
      case (wb_adr)
        addr_control: begin
          enable        <= wb_dat_w[ctrl_enable_bit];
          offset_binary <= wb_dat_w[ctrl_offset_binary_bit];
        end
        addr_mode: begin
          mode0 <= source_mode_e'(wb_dat_w[mode0_lsb +: mode_width]);
          mode1 <= source_mode_e'(wb_dat_w[mode1_lsb +: mode_width]);
        end
        addr_pattern0: pattern0 <= wb_dat_w[pattern_width-1:0];
        addr_pattern1: pattern1 <= wb_dat_w[pattern_width-1:0];
        // Version and unknown addresses ignore writes
        default: ;
      endcase
    end
  end

  // ********************
  // Read back
  // ********************

  // Unknown addresses read as zero
  always_comb begin
    read_data = '0;
    case (wb_adr)
      addr_control: begin
        read_data[ctrl_enable_bit]        = enable;
        read_data[ctrl_offset_binary_bit] = offset_binary;
      end
      addr_mode: begin
        read_data[mode0_lsb +: mode_width] = mode0;
        read_data[mode1_lsb +: mode_width] = mode1;
      end
      addr_pattern0: read_data[pattern_width-1:0] = pattern0;
      addr_pattern1: read_data[pattern_width-1:0] = pattern1;
      addr_version:  read_data = version_value;
      default:       read_data = '0;
    endcase
  end

  // Read data is captured with ack and holds until the next access
  always_ff @(posedge link_clk) begin
    if (access) begin
      wb_dat_r <= read_data;
    end
  end

endmodule

`default_nettype wire

// File: tpl_dac_regs_pkg.sv
/*
 * Register map of the DAC transport layer: bus types, byte addresses,
 * field positions and the per-channel source mode encoding.
 */

`default_nettype none

package tpl_dac_regs_pkg;

  // Wishbone uses byte addresses on a 32-bit data bus
  typedef logic [5:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // ********************
  // Register addresses
  // ********************

  localparam wb_addr_t addr_control  = 6'h00;
  localparam wb_addr_t addr_mode     = 6'h04;
  localparam wb_addr_t addr_pattern0 = 6'h08;
  localparam wb_addr_t addr_pattern1 = 6'h0C;
  localparam wb_addr_t addr_version  = 6'h10;

  // Read-only core version, major 1 minor 0
  localparam wb_data_t version_value = 32'h0001_0000;

  // Field positions in the control register
  localparam int ctrl_enable_bit        = 0;
  localparam int ctrl_offset_binary_bit = 1;

  // Field positions in the mode register, two bits per channel
  localparam int mode_width = 2;
  localparam int mode0_lsb  = 0;
  localparam int mode1_lsb  = 2;

  // Pattern registers use the low half of the word
  localparam int pattern_width = 16;

  // Sample source selected for one channel
  typedef enum logic [mode_width-1:0] {
    mode_zero     = 2'd0,
    mode_pattern  = 2'd1,
    mode_ramp     = 2'd2,
    mode_external = 2'd3
  } source_mode_e;

endpackage

`default_nettype wire

// File: tpl_dac_top.sv
/*
 * Transmit transport layer of a JESD204 DAC link. A Wishbone register
 * map sets up two channel sources whose samples the framer packs into lanes.
 */

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_top
  import tpl_dac_pkg::*;
  import tpl_dac_regs_pkg::*;
(
  input  logic       link_clk,
  input  logic       reset,

  // Wishbone classic slave, clocked by the link clock
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_addr_t   wb_adr,
  input  wb_data_t   wb_dat_w,
  output wb_data_t   wb_dat_r,
  output logic       wb_ack,

  // Link layer side, no back-pressure besides the ready flag
  input  logic       link_ready,
  output link_data_t link_data,

  // User samples for external mode
  input  dac_data_t  dac_data
);

  logic          enable;
  logic          offset_binary;
  source_mode_e  mode0;
  source_mode_e  mode1;
  sample_t       pattern0;
  sample_t       pattern1;
  channel_data_t ch0_external;
  channel_data_t ch1_external;
  channel_data_t ch0_samples;
  channel_data_t ch1_samples;

  // Split the user input into one beat per channel
  assign ch0_external = dac_data[0*channel_width +: channel_width];
  assign ch1_external = dac_data[1*channel_width +: channel_width];

  // ********************
  // Control
  // ********************

  tpl_dac_regmap regmap_i (
    .link_clk      (link_clk),
    .reset         (reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .enable        (enable),
    .offset_binary (offset_binary),
    .mode0         (mode0),
    .mode1         (mode1),
    .pattern0      (pattern0),
    .pattern1      (pattern1)
  );

  // ********************
  // Datapath
  // ********************

  tpl_dac_channel_source src0_i (
    .link_clk      (link_clk),
    .reset         (reset),
    .enable        (enable),
    .offset_binary (offset_binary),
    .link_ready    (link_ready),
    .mode          (mode0),
    .pattern       (pattern0),
    .external      (ch0_external),
    .samples       (ch0_samples)
  );

  tpl_dac_channel_source src1_i (
    .link_clk      (link_clk),
    .reset         (reset),
    .enable        (enable),
    .offset_binary (offset_binary),
    .link_ready    (link_ready),
    .mode          (mode1),
    .pattern       (pattern1),
    .external      (ch1_external),
    .samples       (ch1_samples)
  );

  // Lanes 0 and 1 carry channel 0, lanes 2 and 3 channel 1
  tpl_dac_framer framer_i (
    .link_clk    (link_clk),
    .reset       (reset),
    .ch0_samples (ch0_samples),
    .ch1_samples (ch1_samples),
    .link_data   (link_data)
  );

endmodule

`default_nettype wire
